//--- csr_ram_axil.f
+incdir+logic
logic/dffram_pkg.sv
logic/common_dffram_1a1w1r.sv
logic/axil_write_channel.sv
logic/axil_read_channel.sv
logic/ram_port_arbiter.sv
logic/csr_ram_axil.sv
verification/csr_ram_axil_tb.sv

//--- logic/axil_read_channel.sv
// AXI4-Lite read channel
`timescale 1ns/1ps

module axil_read_channel (
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        arvalid,
    output logic                        arready,
    input  dffram_pkg::axi_addr_t       araddr,

    output logic                        rvalid,
    input  logic                        rready,
    output dffram_pkg::axi_data_t       rdata,
    output dffram_pkg::axi_resp_t       rresp,

    output logic                        rd_req,
    output dffram_pkg::word_index_t     rd_index,
    input  logic                        rd_gnt,
    input  dffram_pkg::axi_data_t       ram_dout
);
    import dffram_pkg::*;

    rd_state_t  state;
    logic       ar_fire;
    logic       ar_in_range;

    assign arready = (state == RD_IDLE);
    assign ar_fire = arvalid & arready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (ar_fire) state <= addr_in_range(araddr) ? RD_REQ : RD_RESP;
                end
                RD_REQ: begin
                    if (rd_gnt) state <= RD_RESP;
                end
                RD_RESP: begin
                    if (rready) state <= RD_IDLE;
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // zero stays in place for an out-of-range read
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_index    <= addr_to_index(araddr);
            ar_in_range <= addr_in_range(araddr);
            rdata       <= '0;
        end else if (rd_gnt) begin
            rdata <= ram_dout;
        end
    end

    assign rd_req = (state == RD_REQ);
    assign rvalid = (state == RD_RESP);
    assign rresp  = ar_in_range ? RESP_OKAY : RESP_SLVERR;

endmodule

//--- logic/axil_write_channel.sv
// AXI4-Lite write channel
`timescale 1ns/1ps

module axil_write_channel (
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        awvalid,
    output logic                        awready,
    input  dffram_pkg::axi_addr_t       awaddr,

    input  logic                        wvalid,
    output logic                        wready,
    input  dffram_pkg::axi_data_t       wdata,
    input  dffram_pkg::axi_strb_t       wstrb,

    output logic                        bvalid,
    input  logic                        bready,
    output dffram_pkg::axi_resp_t       bresp,

    output logic                        wr_req,
    output dffram_pkg::word_index_t     wr_index,
    output dffram_pkg::axi_data_t       wr_bit_en,
    output dffram_pkg::axi_data_t       wr_data,
    input  logic                        wr_gnt
);
    import dffram_pkg::*;

    wr_state_t  state;
    logic       aw_done;
    logic       w_done;
    logic       aw_fire;
    logic       w_fire;
    logic       aw_have;
    logic       w_have;
    logic       aw_in_range;
    logic       in_range_next;
    axi_data_t  bit_en_next;

    assign awready = (state == WR_IDLE) & ~aw_done;
    assign wready  = (state == WR_IDLE) & ~w_done;
    assign aw_fire = awvalid & awready;
    assign w_fire  = wvalid & wready;
    assign aw_have = aw_done | aw_fire;
    assign w_have  = w_done | w_fire;

    // AW may arrive on the same edge as the decision
    assign in_range_next = aw_fire ? addr_in_range(awaddr) : aw_in_range;

    always_comb begin
        for (int b = 0; b < $bits(axi_strb_t); b++) begin
            bit_en_next[8*b +: 8] = {8{wstrb[b]}};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= WR_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (aw_have && w_have) begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= in_range_next ? WR_REQ : WR_RESP;  // no RAM access if out of range
                    end else begin
                        aw_done <= aw_have;
                        w_done  <= w_have;
                    end
                end
                WR_REQ: begin
                    if (wr_gnt) state <= WR_RESP;
                end
                WR_RESP: begin
                    if (bready) state <= WR_IDLE;
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_index    <= addr_to_index(awaddr);
            aw_in_range <= addr_in_range(awaddr);
        end
        if (w_fire) begin
            wr_data   <= wdata;
            wr_bit_en <= bit_en_next;
        end
    end

    assign wr_req = (state == WR_REQ);
    assign bvalid = (state == WR_RESP);
    assign bresp  = aw_in_range ? RESP_OKAY : RESP_SLVERR;

endmodule

//--- logic/common_dffram_1a1w1r.sv
// flip-flop RAM, one address port
`timescale 1ns/1ps

module common_dffram_1a1w1r #(
    parameter int                               RAM_WIDTH         = 1,
    parameter int                               RAM_DEPTH         = 1,
    parameter logic [RAM_DEPTH*RAM_WIDTH-1:0]   RAM_RESET_VALUE   = '0,
    parameter bit                               ONEHOT_ADDRESSING = 1'b0,
    parameter bit                               BIT_WRITE_ENABLE  = 1'b0,
    parameter bit                               DATA_COUPLED      = 1'b0,

    localparam int RAM_PORT_ADDR_WIDTH  = ONEHOT_ADDRESSING ? RAM_DEPTH
                                        : (RAM_DEPTH > 1 ? $clog2(RAM_DEPTH) : 1),
    localparam int RAM_PORT_WE_WIDTH    = BIT_WRITE_ENABLE ? RAM_WIDTH : 1,
    localparam int RAM_PORT_TDATA_WIDTH = DATA_COUPLED ? RAM_DEPTH * RAM_WIDTH : 1
) (
    input  logic                                clk,
    input  logic                                reset,

    input  logic [RAM_PORT_ADDR_WIDTH-1:0]      addr,
    input  logic                                en,
    input  logic [RAM_PORT_WE_WIDTH-1:0]        we,

    input  logic [RAM_WIDTH-1:0]                din,
    output logic [RAM_WIDTH-1:0]                dout,

    output logic [RAM_PORT_TDATA_WIDTH-1:0]     tdout     // whole image, word 0 in the low bits
);

    logic [RAM_DEPTH-1:0]               word_sel;   // one line per word
    logic [RAM_WIDTH-1:0]               we_bits;
    logic [RAM_DEPTH*RAM_WIDTH-1:0]     image;

    // address decode
    generate
        if (ONEHOT_ADDRESSING) begin : g_addr_onehot
            assign word_sel = addr;
        end else begin : g_addr_binary
            always_comb begin
                for (int k = 0; k < RAM_DEPTH; k++) begin
                    word_sel[k] = (addr == RAM_PORT_ADDR_WIDTH'(k));
                end
            end
        end
    endgenerate

    // word mode spreads the single enable over all bits
    generate
        if (BIT_WRITE_ENABLE) begin : g_we_bitwise
            assign we_bits = we;
        end else begin : g_we_word
            assign we_bits = {RAM_WIDTH{we[0]}};
        end
    endgenerate

    for (genvar i = 0; i < RAM_DEPTH; i++) begin : g_words
        logic [RAM_WIDTH-1:0] q;
        logic [RAM_WIDTH-1:0] word_we;

        assign word_we = we_bits & {RAM_WIDTH{en & word_sel[i]}};

        always_ff @(posedge clk) begin
            if (reset) begin
                q <= RAM_RESET_VALUE[RAM_WIDTH*i +: RAM_WIDTH];
            end else begin
                q <= (q & ~word_we) | (din & word_we);   // untouched bits hold
            end
        end

        assign image[RAM_WIDTH*i +: RAM_WIDTH] = q;
    end

    // read data is the OR of all words masked by their select line
    always_comb begin
        dout = '0;
        for (int k = 0; k < RAM_DEPTH; k++) begin
            dout |= image[RAM_WIDTH*k +: RAM_WIDTH] & {RAM_WIDTH{word_sel[k]}};
        end
    end

    generate
        if (DATA_COUPLED) begin : g_coupled
            assign tdout = image;
        end else begin : g_not_coupled
            assign tdout = '0;
        end
    endgenerate

endmodule

//--- logic/csr_ram_axil.sv
// AXI4-Lite register bank
`timescale 1ns/1ps
`include "dffram_macros.svh"

module csr_ram_axil (
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        awvalid,
    output logic                        awready,
    input  dffram_pkg::axi_addr_t       awaddr,
    input  logic                        wvalid,
    output logic                        wready,
    input  dffram_pkg::axi_data_t       wdata,
    input  dffram_pkg::axi_strb_t       wstrb,
    output logic                        bvalid,
    input  logic                        bready,
    output dffram_pkg::axi_resp_t       bresp,

    input  logic                        arvalid,
    output logic                        arready,
    input  dffram_pkg::axi_addr_t       araddr,
    output logic                        rvalid,
    input  logic                        rready,
    output dffram_pkg::axi_data_t       rdata,
    output dffram_pkg::axi_resp_t       rresp,

    output logic [`DFFRAM_DEPTH*`DFFRAM_DATA_WIDTH-1:0] config_words
);
    import dffram_pkg::*;

    logic           wr_req;
    logic           wr_gnt;
    word_index_t    wr_index;
    axi_data_t      wr_bit_en;
    axi_data_t      wr_data;
    logic           rd_req;
    logic           rd_gnt;
    word_index_t    rd_index;
    word_index_t    ram_addr;
    logic           ram_en;
    axi_data_t      ram_we;
    axi_data_t      ram_dout;

    axil_write_channel i_write_channel (
        .clk       (clk),
        .reset     (reset),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .wr_req    (wr_req),
        .wr_index  (wr_index),
        .wr_bit_en (wr_bit_en),
        .wr_data   (wr_data),
        .wr_gnt    (wr_gnt)
    );

    axil_read_channel i_read_channel (
        .clk      (clk),
        .reset    (reset),
        .arvalid  (arvalid),
        .arready  (arready),
        .araddr   (araddr),
        .rvalid   (rvalid),
        .rready   (rready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rd_req   (rd_req),
        .rd_index (rd_index),
        .rd_gnt   (rd_gnt),
        .ram_dout (ram_dout)
    );

    ram_port_arbiter i_arbiter (
        .clk       (clk),
        .reset     (reset),
        .wr_req    (wr_req),
        .wr_index  (wr_index),
        .wr_bit_en (wr_bit_en),
        .wr_gnt    (wr_gnt),
        .rd_req    (rd_req),
        .rd_index  (rd_index),
        .rd_gnt    (rd_gnt),
        .ram_addr  (ram_addr),
        .ram_en    (ram_en),
        .ram_we    (ram_we)
    );

    // binary addressed, byte strobes arrive as bit enables
    common_dffram_1a1w1r #(
        .RAM_WIDTH         (`DFFRAM_DATA_WIDTH),
        .RAM_DEPTH         (`DFFRAM_DEPTH),
        .ONEHOT_ADDRESSING (1'b0),
        .BIT_WRITE_ENABLE  (1'b1),
        .DATA_COUPLED      (1'b1)
    ) i_ram (
        .clk   (clk),
        .reset (reset),
        .addr  (ram_addr),
        .en    (ram_en),
        .we    (ram_we),
        .din   (wr_data),
        .dout  (ram_dout),
        .tdout (config_words)
    );

endmodule

//--- logic/dffram_macros.svh
// register bank sizing

`ifndef DFFRAM_MACROS_SVH
`define DFFRAM_MACROS_SVH

// word width of the RAM and of the AXI data bus
`define DFFRAM_DATA_WIDTH       32

// number of RAM words
`define DFFRAM_DEPTH            16

// AXI byte address width
// 8 bits cover 64 words of 4 bytes, so the top bits mark out-of-range
`define DFFRAM_AXI_ADDR_WIDTH   8

`endif

//--- logic/dffram_pkg.sv
// register bank shared types
`include "dffram_macros.svh"

package dffram_pkg;

    localparam int WORD_LSB    = $clog2(`DFFRAM_DATA_WIDTH / 8);   // byte offset bits
    localparam int INDEX_WIDTH = $clog2(`DFFRAM_DEPTH);

    typedef logic [`DFFRAM_AXI_ADDR_WIDTH-1:0]  axi_addr_t;
    typedef logic [`DFFRAM_DATA_WIDTH-1:0]      axi_data_t;
    typedef logic [`DFFRAM_DATA_WIDTH/8-1:0]    axi_strb_t;
    typedef logic [1:0]                         axi_resp_t;
    typedef logic [INDEX_WIDTH-1:0]             word_index_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {WR_IDLE, WR_REQ, WR_RESP} wr_state_t;
    typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_RESP} rd_state_t;

    // word index inside a byte address
    function automatic word_index_t addr_to_index(axi_addr_t addr);
        return addr[WORD_LSB +: INDEX_WIDTH];
    endfunction

    function automatic logic addr_in_range(axi_addr_t addr);
        return (addr >> (WORD_LSB + INDEX_WIDTH)) == '0;
    endfunction

endpackage

//--- logic/ram_port_arbiter.sv
// RAM port arbiter
`timescale 1ns/1ps

module ram_port_arbiter (
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        wr_req,
    input  dffram_pkg::word_index_t     wr_index,
    input  dffram_pkg::axi_data_t       wr_bit_en,
    output logic                        wr_gnt,

    input  logic                        rd_req,
    input  dffram_pkg::word_index_t     rd_index,
    output logic                        rd_gnt,

    output dffram_pkg::word_index_t     ram_addr,
    output logic                        ram_en,
    output dffram_pkg::axi_data_t       ram_we
);
    import dffram_pkg::*;

    logic rd_won_last;      // winner of the last contested cycle
    logic contested;

    assign contested = wr_req & rd_req;

    // read goes first after reset, then the two alternate
    assign rd_gnt = rd_req & (~wr_req | ~rd_won_last);
    assign wr_gnt = wr_req & (~rd_req | rd_won_last);

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_won_last <= 1'b0;
        end else if (contested) begin
            rd_won_last <= rd_gnt;
        end
    end

    assign ram_addr = wr_gnt ? wr_index : rd_index;
    assign ram_en   = wr_gnt | rd_gnt;
    assign ram_we   = {$bits(axi_data_t){wr_gnt}} & wr_bit_en;   // reads never write

endmodule

//--- verification/csr_ram_axil_tb.sv
// register bank testbench
`timescale 1ns/1ps
`include "dffram_macros.svh"

module csr_ram_axil_tb;

    localparam int  CLK_PERIOD     = 100;
    localparam int  DW             = `DFFRAM_DATA_WIDTH;
    localparam int  AW             = `DFFRAM_AXI_ADDR_WIDTH;
    localparam int  DEPTH          = `DFFRAM_DEPTH;
    localparam int  CYCLES_PER_ROW = 40;

    localparam logic [2:0] OP_WR          = 3'd0;     // AW and W offered together
    localparam logic [2:0] OP_WR_AW_FIRST = 3'd1;
    localparam logic [2:0] OP_WR_W_FIRST  = 3'd2;
    localparam logic [2:0] OP_RD          = 3'd3;
    localparam logic [2:0] OP_WR_RD       = 3'd4;     // write and read issued at once

    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    typedef struct packed {
        logic [2:0]     op;
        logic [AW-1:0]  addr;
        logic [AW-1:0]  addr2;      // read address of a combined row
        logic [DW-1:0]  data;
        logic           rnd;        // data comes from the LFSR
        logic [3:0]     strb;
        logic [1:0]     resp;
    } row_t;

    logic                   clk;
    logic                   reset;
    logic                   awvalid;
    logic                   awready;
    logic [AW-1:0]          awaddr;
    logic                   wvalid;
    logic                   wready;
    logic [DW-1:0]          wdata;
    logic [3:0]             wstrb;
    logic                   bvalid;
    logic                   bready;
    logic [1:0]             bresp;
    logic                   arvalid;
    logic                   arready;
    logic [AW-1:0]          araddr;
    logic                   rvalid;
    logic                   rready;
    logic [DW-1:0]          rdata;
    logic [1:0]             rresp;
    logic [DEPTH*DW-1:0]    config_words;

    logic [DW-1:0]  model [DEPTH];      // expected RAM contents
    logic [31:0]    lfsr;
    row_t           rows [$];
    bit             table_built = 1'b0;
    int             n_checks;
    int             n_errors;

    csr_ram_axil i_csr_ram_axil (
        .clk          (clk),
        .reset        (reset),
        .awvalid      (awvalid),
        .awready      (awready),
        .awaddr       (awaddr),
        .wvalid       (wvalid),
        .wready       (wready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .bvalid       (bvalid),
        .bready       (bready),
        .bresp        (bresp),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp),
        .config_words (config_words)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        wait (table_built);
        repeat (rows.size() * CYCLES_PER_ROW + 20) @(posedge clk);
        $display("watchdog: the %0d table rows did not complete in time", rows.size());
        $display("*** FAILED ***");
        $finish;
    end

    // galois form, taps 32 22 2 1
    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
    endtask

    task automatic check_value(input string name, input logic [DW-1:0] got,
                               input logic [DW-1:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_image();
        for (int k = 0; k < DEPTH; k++) begin
            check_value($sformatf("config_words[%0d]", k), config_words[DW*k +: DW], model[k]);
        end
    endtask

    // out-of-range writes leave the model alone
    task automatic model_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                               input logic [3:0] strb);
        if (addr < 4 * DEPTH) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) model[addr >> 2][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    function automatic logic [DW-1:0] model_read(input logic [AW-1:0] addr);
        return (addr < 4 * DEPTH) ? model[addr >> 2] : '0;
    endfunction

    task automatic add_row(input logic [2:0] op, input logic [AW-1:0] addr,
                           input logic [AW-1:0] addr2, input logic [DW-1:0] data,
                           input logic rnd, input logic [3:0] strb, input logic [1:0] resp);
        row_t r;
        r = '{op, addr, addr2, data, rnd, strb, resp};
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(OP_RD, 8'h00, 8'h00, 32'h0, 1'b0, 4'h0, OKAY);      // reset contents
        add_row(OP_RD, 8'h24, 8'h00, 32'h0, 1'b0, 4'h0, OKAY);
        add_row(OP_RD, 8'h3c, 8'h00, 32'h0, 1'b0, 4'h0, OKAY);
        add_row(OP_WR, 8'h00, 8'h00, 32'h0, 1'b1, 4'hf, OKAY);
        add_row(OP_WR, 8'h04, 8'h00, 32'hdeadbeef, 1'b0, 4'hf, OKAY);
        add_row(OP_WR, 8'h3c, 8'h00, 32'h0, 1'b1, 4'hf, OKAY);
        add_row(OP_WR, 8'h28, 8'h00, 32'h0, 1'b1, 4'hf, OKAY);
        add_row(OP_RD, 8'h00, 8'h00, 32'h0, 1'b0, 4'h0, OKAY);
        add_row(OP_RD, 8'h04, 8'h00, 32'h0, 1'b0, 4'h0, OKAY);
        add_row(OP_RD, 8'h3c, 8'h00, 32'h0, 1'b0, 4'h0, OKAY);
        add_row(OP_RD, 8'h28, 8'h00, 32'h0, 1'b0, 4'h0, OKAY);
        // byte strobes
        add_row(OP_WR, 8'h08, 8'h00, 32'h11223344, 1'b0, 4'hf, OKAY);
        add_row(OP_WR, 8'h08, 8'h00, 32'haabbccdd, 1'b0, 4'h5, OKAY);
        add_row(OP_RD, 8'h08, 8'h00, 32'h0, 1'b0, 4'h0, OKAY);
        add_row(OP_WR, 8'h08, 8'h00, 32'h0, 1'b1, 4'h8, OKAY);
        add_row(OP_RD, 8'h08, 8'h00, 32'h0, 1'b0, 4'h0, OKAY);
        add_row(OP_WR, 8'h0c, 8'h00, 32'h0, 1'b1, 4'h0, OKAY);     // no strobe, no change
        add_row(OP_RD, 8'h0c, 8'h00, 32'h0, 1'b0, 4'h0, OKAY);
        add_row(OP_WR, 8'h04, 8'h00, 32'h0, 1'b1, 4'h2, OKAY);
        add_row(OP_RD, 8'h04, 8'h00, 32'h0, 1'b0, 4'h0, OKAY);
        // beyond the 16 words
        add_row(OP_WR, 8'h40, 8'h00, 32'h0, 1'b1, 4'hf, SLVERR);
        add_row(OP_WR, 8'hfc, 8'h00, 32'h0, 1'b1, 4'hf, SLVERR);
        add_row(OP_RD, 8'h40, 8'h00, 32'h0, 1'b0, 4'h0, SLVERR);
        add_row(OP_RD, 8'h80, 8'h00, 32'h0, 1'b0, 4'h0, SLVERR);
        add_row(OP_RD, 8'h00, 8'h00, 32'h0, 1'b0, 4'h0, OKAY);
        // channel order
        add_row(OP_WR_AW_FIRST, 8'h10, 8'h00, 32'h0, 1'b1, 4'hf, OKAY);
        add_row(OP_WR_W_FIRST, 8'h14, 8'h00, 32'h0, 1'b1, 4'hf, OKAY);
        add_row(OP_RD, 8'h10, 8'h00, 32'h0, 1'b0, 4'h0, OKAY);
        add_row(OP_RD, 8'h14, 8'h00, 32'h0, 1'b0, 4'h0, OKAY);
        add_row(OP_WR_W_FIRST, 8'h44, 8'h00, 32'h0, 1'b1, 4'hf, SLVERR);
        add_row(OP_WR_AW_FIRST, 8'h3c, 8'h00, 32'h0, 1'b1, 4'h3, OKAY);
        add_row(OP_RD, 8'h3c, 8'h00, 32'h0, 1'b0, 4'h0, OKAY);
        // both channels busy at once, so the arbiter sees contention
        add_row(OP_WR_RD, 8'h18, 8'h00, 32'h0, 1'b1, 4'hf, OKAY);
        add_row(OP_WR_RD, 8'h1c, 8'h18, 32'h0, 1'b1, 4'hf, OKAY);
        add_row(OP_WR_RD, 8'h20, 8'h1c, 32'h0, 1'b1, 4'hf, OKAY);
        add_row(OP_WR_RD, 8'h2c, 8'h20, 32'h0, 1'b1, 4'h6, OKAY);
        add_row(OP_RD, 8'h2c, 8'h00, 32'h0, 1'b0, 4'h0, OKAY);
    endtask

    // the bus tasks start and end on a falling edge
    task automatic send_aw(input logic [AW-1:0] addr);
        awvalid = 1'b1;
        awaddr  = addr;
        while (!awready) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
    endtask

    task automatic send_w(input logic [DW-1:0] data, input logic [3:0] strb);
        wvalid = 1'b1;
        wdata  = data;
        wstrb  = strb;
        while (!wready) @(negedge clk);
        @(negedge clk);
        wvalid = 1'b0;
    endtask

    task automatic send_ar(input logic [AW-1:0] addr);
        arvalid = 1'b1;
        araddr  = addr;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
    endtask

    task automatic recv_b(input int delay, output logic [1:0] resp);
        while (!bvalid) @(negedge clk);
        repeat (delay) @(negedge clk);      // back-pressure
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic recv_r(input int delay, output logic [DW-1:0] data, output logic [1:0] resp);
        while (!rvalid) @(negedge clk);
        repeat (delay) @(negedge clk);
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic run_row(input row_t r);
        logic [DW-1:0]  wr_data;
        logic [DW-1:0]  exp_data;
        logic [DW-1:0]  got_data;
        logic [1:0]     got_bresp;
        logic [1:0]     got_rresp;
        logic [31:0]    b_delay;
        logic [31:0]    r_delay;

        wr_data = r.data;
        if (r.rnd) take_bits(DW, wr_data);
        take_bits(2, b_delay);
        take_bits(2, r_delay);
        exp_data = model_read((r.op == OP_WR_RD) ? r.addr2 : r.addr);
        case (r.op)
            OP_WR: fork
                send_aw(r.addr);
                send_w(wr_data, r.strb);
                recv_b(b_delay, got_bresp);
            join
            OP_WR_AW_FIRST: begin
                send_aw(r.addr);
                send_w(wr_data, r.strb);
                recv_b(b_delay, got_bresp);
            end
            OP_WR_W_FIRST: begin
                send_w(wr_data, r.strb);
                send_aw(r.addr);
                recv_b(b_delay, got_bresp);
            end
            OP_RD: begin
                send_ar(r.addr);
                recv_r(r_delay, got_data, got_rresp);
            end
            default: fork
                send_aw(r.addr);
                send_w(wr_data, r.strb);
                recv_b(b_delay, got_bresp);
                send_ar(r.addr2);
                recv_r(r_delay, got_data, got_rresp);
            join
        endcase
        if (r.op != OP_RD) begin
            check_value("bresp", got_bresp, r.resp);
            model_write(r.addr, wr_data, r.strb);
        end
        if (r.op == OP_RD || r.op == OP_WR_RD) begin
            check_value("rresp", got_rresp, r.resp);
            check_value("rdata", got_data, exp_data);
        end
        check_image();      // idle point
    endtask

    initial begin
        reset   = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        lfsr    = 32'hab452258;
        n_checks = 0;
        n_errors = 0;
        for (int k = 0; k < DEPTH; k++) begin
            model[k] = '0;
        end
        build_table();
        table_built = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_image();
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        repeat (2) @(negedge clk);
        $display("rows: %0d, checks: %0d, errors: %0d", rows.size(), n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
